/* hdl/apple_placer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snake_params.svh"

module apple_placer
(
    input  wire               clk_25Mhz,
    input  wire               reset,
    input  wire               apple_req,
    input  wire               frame_start,
    output logic              apple_ack,
    output snake_pkg::coord_t apple_x,
    output snake_pkg::coord_t apple_y,
    output logic              apple_shown
);

    import snake_pkg::*;

    localparam coord_t X_BASE   = coord_t'(`APPLE_X_BASE);
    localparam coord_t Y_BASE   = coord_t'(`APPLE_Y_BASE);
    // Second half of the field for bit 8
    localparam coord_t X_HALF   = coord_t'(224);
    localparam coord_t IN_LEFT  = coord_t'(`FIELD_LEFT + `BORDER_WIDTH);
    localparam coord_t IN_TOP   = coord_t'(`FIELD_TOP + `BORDER_WIDTH);
    localparam coord_t IN_RIGHT = coord_t'(`FIELD_RIGHT - `BORDER_WIDTH - `APPLE_SIZE);
    localparam coord_t IN_BOT   = coord_t'(`FIELD_BOTTOM - `BORDER_WIDTH - `APPLE_SIZE);

    apple_state_t state;
    logic [15:0]  lfsr;
    logic [15:0]  lfsr_next;
    coord_t       pending_x;
    coord_t       pending_y;

    always_comb
    begin
        // Galois step, shift right and fold taps on the dropped bit
        lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `LFSR_TAPS) : (lfsr >> 1);
        pending_x = X_BASE + coord_t'(lfsr[7:0]) + (lfsr[8] ? X_HALF : coord_t'(0));
        pending_y = Y_BASE + coord_t'(lfsr[15:9]) + coord_t'(lfsr[15:12]);
    end

    always_ff @(posedge clk_25Mhz)
    begin
        if (reset)
        begin
            state       <= APPLE_IDLE;
            lfsr        <= `LFSR_SEED;
            apple_ack   <= 1'b0;
            apple_shown <= 1'b0;
        end
        else
        begin
            case (state)
                APPLE_IDLE:
                begin
                    if (apple_req)
                    begin
                        lfsr  <= lfsr_next;
                        state <= APPLE_STEPPED;
                    end
                end
                APPLE_STEPPED:
                begin
                    // Switch position only between frames
                    if (frame_start)
                    begin
                        apple_shown <= 1'b1;
                        state       <= APPLE_ACKED;
                    end
                end
                APPLE_ACKED:
                begin
                    if (!apple_ack)
                        apple_ack <= 1'b1;
                    else if (!apple_req)
                    begin
                        apple_ack <= 1'b0;
                        state     <= APPLE_IDLE;
                    end
                end
                default:
                    state <= APPLE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_25Mhz)
    begin
        if ((state == APPLE_STEPPED) && frame_start)
        begin
            apple_x <= pending_x;
            apple_y <= pending_y;
        end
    end

    ack_needs_req: assert property (@(posedge clk_25Mhz) disable iff (reset)
        $rose(apple_ack) |-> apple_req);

    apple_inside: assert property (@(posedge clk_25Mhz) disable iff (reset)
        apple_shown |-> (apple_x >= IN_LEFT) && (apple_x <= IN_RIGHT)
                        && (apple_y >= IN_TOP) && (apple_y <= IN_BOT));

endmodule

`default_nettype wire

/* hdl/field_layers.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snake_params.svh"

module field_layers
(
    input  wire                    clk_25Mhz,
    input  wire                    reset,
    input  wire snake_pkg::coord_t column,
    input  wire snake_pkg::coord_t row,
    input  wire snake_pkg::coord_t apple_x,
    input  wire snake_pkg::coord_t apple_y,
    input  wire                    apple_shown,
    input  wire                    display_enable,
    output snake_pkg::pix_color_t  color
);

    import snake_pkg::*;

    localparam int     NUM_LAYERS = 5;
    localparam coord_t F_LEFT     = coord_t'(`FIELD_LEFT);
    localparam coord_t F_TOP      = coord_t'(`FIELD_TOP);
    localparam coord_t F_RIGHT    = coord_t'(`FIELD_RIGHT);
    localparam coord_t F_BOTTOM   = coord_t'(`FIELD_BOTTOM);
    localparam coord_t BW         = coord_t'(`BORDER_WIDTH);
    localparam coord_t APPLE_SZ   = coord_t'(`APPLE_SIZE);

    pix_color_t layer_q [NUM_LAYERS];
    pix_color_t merged;

    // Start inclusive, end exclusive
    function automatic logic in_rect(input coord_t x, input coord_t y,
                                     input coord_t x0, input coord_t y0,
                                     input coord_t x1, input coord_t y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    // Overlap of two drawn layers keeps the common bits
    function automatic pix_color_t merge_layer(input pix_color_t acc, input pix_color_t nxt);
        if (acc != '0)
            return (nxt != '0) ? (acc & nxt) : acc;
        else
            return nxt;
    endfunction

    // Stage one, one colour per layer
    always_ff @(posedge clk_25Mhz)
    begin
        layer_q[0] <= (apple_shown && in_rect(column, row, apple_x, apple_y,
                                              apple_x + APPLE_SZ, apple_y + APPLE_SZ))
                      ? `APPLE_COLOR : '0;
        layer_q[1] <= in_rect(column, row, F_LEFT, F_TOP, F_RIGHT, F_TOP + BW)
                      ? `BORDER_COLOR : '0;
        layer_q[2] <= in_rect(column, row, F_LEFT, F_BOTTOM - BW, F_RIGHT, F_BOTTOM)
                      ? `BORDER_COLOR : '0;
        layer_q[3] <= in_rect(column, row, F_LEFT, F_TOP, F_LEFT + BW, F_BOTTOM)
                      ? `BORDER_COLOR : '0;
        layer_q[4] <= in_rect(column, row, F_RIGHT - BW, F_TOP, F_RIGHT, F_BOTTOM)
                      ? `BORDER_COLOR : '0;
    end

    always_comb
    begin
        merged = layer_q[0];
        for (int i = 1; i < NUM_LAYERS; i++)
        begin
            merged = merge_layer(merged, layer_q[i]);
        end
    end

    // Stage two, merged colour with blanking
    always_ff @(posedge clk_25Mhz)
    begin
        if (reset)
            color <= '0;
        else if (!display_enable)
            color <= '0;
        else
            color <= merged;
    end

endmodule

`default_nettype wire

/* hdl/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snake_params.svh"

module raster_timing
(
    input  wire                clk_25Mhz,
    input  wire                reset,
    output snake_pkg::coord_t  column,
    output snake_pkg::coord_t  row,
    output logic               visible,
    output logic               hsync,
    output logic               vsync,
    output snake_pkg::pix_addr_t addr,
    output logic               frame_start
);

    import snake_pkg::*;

    localparam coord_t H_LAST   = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(`V_TOTAL - 1);
    localparam coord_t H_VIS    = coord_t'(`H_VISIBLE);
    localparam coord_t V_VIS    = coord_t'(`V_VISIBLE);
    localparam coord_t HS_START = coord_t'(`H_SYNC_START);
    localparam coord_t HS_END   = coord_t'(`H_SYNC_END);
    localparam coord_t VS_START = coord_t'(`V_SYNC_START);
    localparam coord_t VS_END   = coord_t'(`V_SYNC_END);

    coord_t column_next;
    coord_t row_next;
    logic   frame_wrap;

    always_comb
    begin
        frame_wrap = (column == H_LAST) && (row == V_LAST);
        if (column == H_LAST)
        begin
            column_next = '0;
            row_next    = (row == V_LAST) ? '0 : row + coord_t'(1);
        end
        else
        begin
            column_next = column + coord_t'(1);
            row_next    = row;
        end
    end

    // Flags are registered from the next position so they line up with the counters
    always_ff @(posedge clk_25Mhz)
    begin
        if (reset)
        begin
            column      <= '0;
            row         <= '0;
            visible     <= 1'b1;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            frame_start <= 1'b1;
            addr        <= '0;
        end
        else
        begin
            column      <= column_next;
            row         <= row_next;
            visible     <= (column_next < H_VIS) && (row_next < V_VIS);
            hsync       <= !((column_next >= HS_START) && (column_next < HS_END));
            vsync       <= !((row_next >= VS_START) && (row_next < VS_END));
            frame_start <= frame_wrap;
            // Address only moves on visible pixels
            if (frame_wrap)
                addr <= '0;
            else if (visible)
                addr <= addr + pix_addr_t'(1);
        end
    end

    column_in_range: assert property (@(posedge clk_25Mhz) column < coord_t'(`H_TOTAL));

endmodule

`default_nettype wire

/* hdl/snake_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snake_display_top
(
    input  wire                   clk_25Mhz,
    input  wire                   reset,
    input  wire                   display_enable,
    input  wire                   apple_req,
    output logic                  apple_ack,
    output snake_pkg::pix_addr_t  pixel_addr,
    output logic                  pixel_visible,
    output snake_pkg::pix_color_t pixel_color,
    output logic                  hsync,
    output logic                  vsync
);

    import snake_pkg::*;

    coord_t    column;
    coord_t    row;
    logic      visible_raw;
    logic      hsync_raw;
    logic      vsync_raw;
    pix_addr_t addr_raw;
    logic      frame_start;
    coord_t    apple_x;
    coord_t    apple_y;
    logic      apple_shown;

    pix_addr_t addr_q1;
    logic      visible_q1;
    logic      hsync_q1;
    logic      vsync_q1;

    raster_timing raster
    (
        .clk_25Mhz   (clk_25Mhz),
        .reset       (reset),
        .column      (column),
        .row         (row),
        .visible     (visible_raw),
        .hsync       (hsync_raw),
        .vsync       (vsync_raw),
        .addr        (addr_raw),
        .frame_start (frame_start)
    );

    apple_placer placer
    (
        .clk_25Mhz   (clk_25Mhz),
        .reset       (reset),
        .apple_req   (apple_req),
        .frame_start (frame_start),
        .apple_ack   (apple_ack),
        .apple_x     (apple_x),
        .apple_y     (apple_y),
        .apple_shown (apple_shown)
    );

    field_layers layers
    (
        .clk_25Mhz      (clk_25Mhz),
        .reset          (reset),
        .column         (column),
        .row            (row),
        .apple_x        (apple_x),
        .apple_y        (apple_y),
        .apple_shown    (apple_shown),
        .display_enable (display_enable),
        .color          (pixel_color)
    );

    // Match the two colour stages
    always_ff @(posedge clk_25Mhz)
    begin
        if (reset)
        begin
            visible_q1    <= 1'b0;
            hsync_q1      <= 1'b1;
            vsync_q1      <= 1'b1;
            pixel_visible <= 1'b0;
            hsync         <= 1'b1;
            vsync         <= 1'b1;
        end
        else
        begin
            visible_q1    <= visible_raw;
            hsync_q1      <= hsync_raw;
            vsync_q1      <= vsync_raw;
            pixel_visible <= visible_q1;
            hsync         <= hsync_q1;
            vsync         <= vsync_q1;
        end
    end

    always_ff @(posedge clk_25Mhz)
    begin
        addr_q1    <= addr_raw;
        pixel_addr <= addr_q1;
    end

endmodule

`default_nettype wire

/* hdl/snake_pkg.sv */
`default_nettype none

package snake_pkg;

    // 4 bits per channel, zero is black or empty layer
    typedef logic [11:0] pix_color_t;

    typedef logic [10:0] coord_t;

    // Row times 640 plus column
    typedef logic [18:0] pix_addr_t;

    // Apple relocation handshake
    typedef enum logic [1:0]
    {
        APPLE_IDLE,
        APPLE_STEPPED,
        APPLE_ACKED
    } apple_state_t;

endpackage

`default_nettype wire

/* include/snake_params.svh */
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// 640x480 raster, 25 MHz pixel clock
`define H_VISIBLE       640
`define H_SYNC_START    656
`define H_SYNC_END      752
`define H_TOTAL         800

`define V_VISIBLE       480
`define V_SYNC_START    490
`define V_SYNC_END      492
`define V_TOTAL         525

// Playfield box, borders are the bands just inside it
`define FIELD_LEFT      210
`define FIELD_TOP       200
`define FIELD_RIGHT     720
`define FIELD_BOTTOM    470
`define BORDER_WIDTH    10

`define APPLE_SIZE      10
`define APPLE_X_BASE    220
`define APPLE_Y_BASE    210

`define BORDER_COLOR    12'h0F0
`define APPLE_COLOR     12'hF00

`define LFSR_SEED       16'hACE1
`define LFSR_TAPS       16'hB400

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the snake display testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_snake_display
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" \
    --Mdir "$BUILD_DIR" -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* tests/snake_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snake_params.svh"

module snake_display_checker
(
    input  wire                        clk_25Mhz,
    input  wire                        reset,
    input  wire                        display_enable,
    input  wire                        apple_req,
    input  wire                        apple_ack,
    input  wire snake_pkg::pix_addr_t  pixel_addr,
    input  wire                        pixel_visible,
    input  wire snake_pkg::pix_color_t pixel_color,
    input  wire                        hsync,
    input  wire                        vsync,
    output int                         errors,
    output int                         frames
);

    import snake_pkg::*;

    // Worst case is a request that just misses a frame start
    localparam int ACK_LIMIT = `H_TOTAL * `V_TOTAL + 2;

    int          error_count = 0;
    int          frame_count = 0;
    logic [15:0] lfsr_ref = `LFSR_SEED;
    int          apple_x = 0;
    int          apple_y = 0;
    int          pend_x = 0;
    int          pend_y = 0;
    logic        apple_on = 1'b0;
    logic        pend_on = 1'b0;
    logic        locked = 1'b0;
    int          col = 0;
    int          row = 0;
    int          ack_wait = 0;
    logic        en_d = 1'b1;
    logic        reset_d = 1'b0;
    logic        req_d = 1'b0;
    logic        ack_d = 1'b0;

    assign errors = error_count;
    assign frames = frame_count;

    function automatic logic [15:0] lfsr_step(input logic [15:0] v);
        logic [15:0] shifted;
        shifted = {1'b0, v[15:1]};
        return v[0] ? (shifted ^ `LFSR_TAPS) : shifted;
    endfunction

    function automatic int apple_col(input logic [15:0] v);
        return `APPLE_X_BASE + int'(v[7:0]) + (v[8] ? 224 : 0);
    endfunction

    function automatic int apple_row(input logic [15:0] v);
        return `APPLE_Y_BASE + int'(v[15:9]) + int'(v[15:12]);
    endfunction

    function automatic logic inside_box(input int x, input int y, input int x0, input int y0,
                                        input int x1, input int y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    function automatic pix_color_t expected_color(input int x, input int y, input logic shown,
                                                  input int ax, input int ay, input logic en);
        pix_color_t layers [5];
        pix_color_t result;
        layers[0] = (shown && inside_box(x, y, ax, ay, ax + `APPLE_SIZE, ay + `APPLE_SIZE))
                    ? `APPLE_COLOR : 12'h000;
        layers[1] = inside_box(x, y, `FIELD_LEFT, `FIELD_TOP, `FIELD_RIGHT,
                               `FIELD_TOP + `BORDER_WIDTH) ? `BORDER_COLOR : 12'h000;
        layers[2] = inside_box(x, y, `FIELD_LEFT, `FIELD_BOTTOM - `BORDER_WIDTH, `FIELD_RIGHT,
                               `FIELD_BOTTOM) ? `BORDER_COLOR : 12'h000;
        layers[3] = inside_box(x, y, `FIELD_LEFT, `FIELD_TOP, `FIELD_LEFT + `BORDER_WIDTH,
                               `FIELD_BOTTOM) ? `BORDER_COLOR : 12'h000;
        layers[4] = inside_box(x, y, `FIELD_RIGHT - `BORDER_WIDTH, `FIELD_TOP, `FIELD_RIGHT,
                               `FIELD_BOTTOM) ? `BORDER_COLOR : 12'h000;
        result = 12'h000;
        foreach (layers[i])
        begin
            // Two drawn layers keep their common bits, else the drawn one wins
            if ((result != 12'h000) && (layers[i] != 12'h000))
                result = result & layers[i];
            else
                result = result | layers[i];
        end
        return en ? result : 12'h000;
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want)
        begin
            error_count++;
            $display("ERR %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic check_handshake();
        if (apple_ack && !ack_d)
        begin
            if (!apple_req)
            begin
                error_count++;
                $display("apple_ack rose while apple_req was low");
            end
            lfsr_ref = lfsr_step(lfsr_ref);
            pend_x   = apple_col(lfsr_ref);
            pend_y   = apple_row(lfsr_ref);
            pend_on  = 1'b1;
            ack_wait = 0;
        end
        if (apple_req && !apple_ack)
        begin
            ack_wait++;
            if (ack_wait == ACK_LIMIT + 1)
            begin
                error_count++;
                $display("apple_ack took longer than one frame plus 2 cycles");
            end
        end
        if (ack_d && apple_ack && !req_d)
        begin
            error_count++;
            $display("apple_ack stayed high after apple_req dropped");
        end
        if (ack_d && !apple_ack && req_d)
        begin
            error_count++;
            $display("apple_ack fell while apple_req was still high");
        end
    endtask

    task automatic check_raster();
        int         px;
        int         py;
        logic       want_vis;
        pix_color_t want_color;
        if (pixel_visible && (pixel_addr == '0))
        begin
            locked = 1'b1;
            col    = 0;
            row    = 0;
            frame_count++;
            // Pending apple shows from this frame on
            if (pend_on)
            begin
                apple_x  = pend_x;
                apple_y  = pend_y;
                apple_on = 1'b1;
                pend_on  = 1'b0;
            end
        end
        else if (locked)
        begin
            col = (col == `H_TOTAL - 1) ? 0 : col + 1;
            if (col == 0)
                row = (row == `V_TOTAL - 1) ? 0 : row + 1;
        end
        if (!locked)
            return;
        want_vis = (col < `H_VISIBLE) && (row < `V_VISIBLE);
        expect_value("pixel_visible", 32'(pixel_visible), 32'(want_vis));
        expect_value("hsync", 32'(hsync), 32'(!((col >= `H_SYNC_START) && (col < `H_SYNC_END))));
        expect_value("vsync", 32'(vsync), 32'(!((row >= `V_SYNC_START) && (row < `V_SYNC_END))));
        if (want_vis)
        begin
            expect_value("pixel_addr", 32'(pixel_addr), 32'(row * `H_VISIBLE + col));
            px = int'(pixel_addr) % `H_VISIBLE;
            py = int'(pixel_addr) / `H_VISIBLE;
            want_color = expected_color(px, py, apple_on, apple_x, apple_y, en_d);
            if (pixel_color !== want_color)
            begin
                error_count++;
                $display("ERR pixel_color at pixel_addr %h: got %h expected %h",
                         pixel_addr, pixel_color, want_color);
            end
        end
    endtask

    // Sampled mid-cycle, away from the rising edge
    always @(negedge clk_25Mhz)
    begin
        if (reset)
        begin
            if (reset_d)
            begin
                expect_value("apple_ack", 32'(apple_ack), 32'h0);
                expect_value("pixel_visible", 32'(pixel_visible), 32'h0);
                expect_value("pixel_color", 32'(pixel_color), 32'h0);
                expect_value("hsync", 32'(hsync), 32'h1);
                expect_value("vsync", 32'(vsync), 32'h1);
            end
            locked   = 1'b0;
            lfsr_ref = `LFSR_SEED;
            apple_on = 1'b0;
            pend_on  = 1'b0;
            ack_wait = 0;
        end
        else
        begin
            check_handshake();
            check_raster();
        end
        // Colour stage two saw the enable of one cycle earlier
        en_d    = display_enable;
        reset_d = reset;
        req_d   = apple_req;
        ack_d   = apple_ack;
    end

endmodule

`default_nettype wire

/* tests/tb_snake_display.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snake_params.svh"

module tb_snake_display;

    import snake_pkg::*;

    localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
    localparam int CYCLE_LIMIT    = 8 * FRAME_CYCLES + 20000;
    localparam int ACK_WAIT_LIMIT = FRAME_CYCLES + 8;
    localparam int ENABLE_OFF_AT  = 3 * FRAME_CYCLES + 100000;
    localparam int ENABLE_OFF_LEN = 150000;
    localparam int MIN_FRAMES     = 7;

    logic       clk_25Mhz = 1'b0;
    logic       reset;
    logic       display_enable;
    logic       apple_req;
    logic       apple_ack;
    pix_addr_t  pixel_addr;
    logic       pixel_visible;
    pix_color_t pixel_color;
    logic       hsync;
    logic       vsync;
    int         checker_errors;
    int         frames_seen;
    int         tb_errors = 0;
    int         cycles = 0;

    always #20 clk_25Mhz = ~clk_25Mhz;

    snake_display_top DUT
    (
        .clk_25Mhz      (clk_25Mhz),
        .reset          (reset),
        .display_enable (display_enable),
        .apple_req      (apple_req),
        .apple_ack      (apple_ack),
        .pixel_addr     (pixel_addr),
        .pixel_visible  (pixel_visible),
        .pixel_color    (pixel_color),
        .hsync          (hsync),
        .vsync          (vsync)
    );

    snake_display_checker scoreboard
    (
        .clk_25Mhz      (clk_25Mhz),
        .reset          (reset),
        .display_enable (display_enable),
        .apple_req      (apple_req),
        .apple_ack      (apple_ack),
        .pixel_addr     (pixel_addr),
        .pixel_visible  (pixel_visible),
        .pixel_color    (pixel_color),
        .hsync          (hsync),
        .vsync          (vsync),
        .errors         (checker_errors),
        .frames         (frames_seen)
    );

    always @(posedge clk_25Mhz)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // Each wait ends 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk_25Mhz);
            #2;
        end
    endtask

    task automatic request_apple();
        int waited;
        int hold;
        waited    = 0;
        apple_req = 1'b1;
        while (!apple_ack && (waited < ACK_WAIT_LIMIT))
        begin
            wait_cycles(1);
            waited++;
        end
        if (!apple_ack)
        begin
            tb_errors++;
            $display("apple_ack did not rise within %0d cycles of the request", waited);
        end
        // Req held past ack must not step the LFSR again
        hold = $urandom_range(0, 40);
        wait_cycles(hold);
        apple_req = 1'b0;
        waited    = 0;
        while (apple_ack && (waited < 8))
        begin
            wait_cycles(1);
            waited++;
        end
        if (apple_ack)
        begin
            tb_errors++;
            $display("apple_ack did not fall after apple_req dropped");
        end
    endtask

    task automatic finish_run();
        int total;
        total = tb_errors + checker_errors;
        if (frames_seen < MIN_FRAMES)
        begin
            total++;
            $display("The checker saw only %0d frames", frames_seen);
        end
        $display("Errors: %0d total, %0d checker, %0d testbench",
                 total, checker_errors, tb_errors);
        if (total == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    // Blank part of a frame while an apple is on screen
    initial
    begin
        repeat (ENABLE_OFF_AT) @(posedge clk_25Mhz);
        #2 display_enable = 1'b0;
        repeat (ENABLE_OFF_LEN) @(posedge clk_25Mhz);
        #2 display_enable = 1'b1;
    end

    initial
    begin
        void'($urandom(32'h38af));
        reset          = 1'b1;
        display_enable = 1'b1;
        apple_req      = 1'b0;
        wait_cycles(4);
        reset = 1'b0;
        // Frame 0 shows borders only
        wait_cycles(10);
        request_apple();
        for (int n = 0; n < 4; n++)
        begin
            wait_cycles($urandom_range(1, 64));
            request_apple();
        end
        // Mid-frame reset while the last apple is drawn
        wait_cycles(200000);
        reset = 1'b1;
        wait_cycles(4);
        reset = 1'b0;
        wait_cycles(10);
        request_apple();
        wait_cycles(FRAME_CYCLES);
        finish_run();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hdl/snake_pkg.sv
hdl/raster_timing.sv
hdl/apple_placer.sv
hdl/field_layers.sv
hdl/snake_display_top.sv
tests/snake_display_checker.sv
tests/tb_snake_display.sv
